//--- tb/game_vectors.txt
0000000000000000000000000000000000000000000000000000000000000010
0000000000008000000000000000000000000000000000000000000000000000
0 4 0 0 3  0 4 0 2 5  0 0 0 0 0  15 15 0 0 0
1 2 0 0 3  1 1 1 2 5  0 0 2 0 0  15 15 1 1 1
1 3 0 0 3  1 0 1 2 5  0 0 3 0 0  15 15 0 0 1
1 3 0 0 3  1 0 1 2 5  1 0 3 0 0  15 14 0 0 1
1 3 1 1 3  1 0 1 2 5  1 0 3 1 1  15 14 0 1 2
1 3 1 1 3  1 0 1 2 5  2 0 3 0 1  15 13 0 0 2
1 3 1 1 3  1 0 1 2 5  2 0 3 0 1  15 13 0 0 2
1 3 1 1 3  1 0 1 2 5  3 0 3 1 2  15 13 0 1 3
1 3 1 1 3  1 3 1 2 5  3 0 3 0 2  15 13 3 0 3
1 3 1 1 3  1 3 1 2 5  3 0 3 0 2  15 13 3 0 3
1 0 1 3 3  1 2 1 2 5  3 0 0 0 2  15 13 2 1 4
1 0 1 3 3  1 2 1 2 5  3 0 0 0 2  14 13 2 0 4
1 1 1 2 3  1 2 1 2 5  3 0 1 1 3  14 13 2 0 4
0 2 0 0 3  1 2 1 2 5  3 0 2 0 3  13 13 2 1 5
0 4 0 0 3  1 2 1 2 5  3 0 2 0 3  13 13 2 0 5
1 1 0 0 3  1 2 1 2 5  3 1 1 0 3  12 13 2 0 5
1 4 0 0 3  1 4 1 2 5  3 1 1 0 3  12 13 2 1 6
1 1 0 0 3  1 4 1 2 5  3 2 1 0 3  12 13 2 0 6
0 4 0 0 3  1 4 1 2 5  3 2 1 0 3  12 13 2 0 6
0 4 0 0 3  1 4 1 2 5  3 2 1 0 3  12 13 2 1 7
0 4 0 0 3  1 4 1 2 5  3 2 1 0 3  12 13 2 0 7
0 4 0 0 3  1 4 1 2 5  3 2 1 0 3  12 13 2 0 7
0 4 0 0 3  1 4 1 2 5  3 2 1 0 3  12 13 2 1 0
0 4 0 0 3  1 4 1 2 5  3 2 1 0 3  12 13 2 0 0
0 4 0 0 3  1 4 1 2 5  3 2 1 0 3  12 13 2 0 0
0 4 0 0 3  1 4 1 2 5  3 2 1 0 3  12 13 2 1 1
0 4 0 0 3  1 4 1 5 5  3 2 1 0 3  12 13 2 0 1
0 4 0 0 3  1 4 1 5 5  3 2 1 0 3  12 13 2 0 1
0 4 0 0 3  1 4 1 5 5  3 2 1 0 3  12 13 2 0 1

//--- verilog.f
source/bomb_game_pkg.sv
source/player_cmd_if.sv
source/move_unit.sv
source/bomb_unit.sv
source/game_controller.sv
tb/tb_game_controller.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the game controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_game_controller \
    -f verilog.f \
    --Mdir obj_dir -o tb_sim

if ./obj_dir/tb_sim > sim.log 2>&1; then
    sim_status=0
else
    sim_status=1
fi
cat sim.log

if [ "$sim_status" -ne 0 ] || grep -q "Testbench failed" sim.log; then
    echo "simulation run reported a failure"
    exit 1
fi
echo "simulation run completed cleanly"

//--- tb/tb_game_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_game_controller;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_VEC    = 64;
    localparam int NUM_COL    = 20;
    localparam string VEC_FILE = "tb/game_vectors.txt";

    logic clk;
    logic rst;

    logic                                   p1_valid_i;
    logic                                   p2_valid_i;
    logic [bomb_game_pkg::DIR_W-1:0]        p1_dir_i;
    logic [bomb_game_pkg::DIR_W-1:0]        p2_dir_i;
    logic                                   p1_bomb_i;
    logic                                   p2_bomb_i;
    logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p1_bomb_num_i;
    logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p1_bomb_max_i;
    logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p2_bomb_num_i;
    logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p2_bomb_max_i;
    logic [bomb_game_pkg::CELL_COUNT-1:0]   wall_map_i;
    logic [bomb_game_pkg::CELL_COUNT-1:0]   bomb_map_i;

    logic [bomb_game_pkg::COORD_W-1:0]      p1_x_o;
    logic [bomb_game_pkg::COORD_W-1:0]      p1_y_o;
    logic [bomb_game_pkg::COORD_W-1:0]      p2_x_o;
    logic [bomb_game_pkg::COORD_W-1:0]      p2_y_o;
    logic [bomb_game_pkg::CELL_W-1:0]       p1_cell_o;
    logic [bomb_game_pkg::CELL_W-1:0]       p2_cell_o;
    logic [bomb_game_pkg::FACE_W-1:0]       p1_face_o;
    logic [bomb_game_pkg::FACE_W-1:0]       p2_face_o;
    logic                                   p1_set_bomb_o;
    logic                                   p2_set_bomb_o;
    logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p1_bomb_count_o;
    logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p2_bomb_count_o;

    // one row per cycle, inputs in columns 0..9, expected outputs in 10..19
    int vec [MAX_VEC][NUM_COL];
    int num_vec = 0;
    bit vectors_loaded = 1'b0;
    int error_count = 0;
    int check_count = 0;

    game_controller uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_field(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // maps first, then one line of 20 decimal fields per cycle
    task automatic load_vectors(output bit ok);
        int fd;
        int n_read;
        int fields [NUM_COL];
        ok = 1'b0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open vector file %s", VEC_FILE);
        end else begin
            n_read = $fscanf(fd, "%h\n", wall_map_i);
            if (n_read == 1) begin
                n_read = $fscanf(fd, "%h\n", bomb_map_i);
            end
            if (n_read != 1) begin
                $display("vector file %s ends before both board maps are read", VEC_FILE);
            end else begin
                ok = 1'b1;
                while (ok && !$feof(fd) && num_vec < MAX_VEC) begin
                    n_read = $fscanf(fd,
                        "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d\n",
                        fields[0], fields[1], fields[2], fields[3], fields[4],
                        fields[5], fields[6], fields[7], fields[8], fields[9],
                        fields[10], fields[11], fields[12], fields[13], fields[14],
                        fields[15], fields[16], fields[17], fields[18], fields[19]);
                    if (n_read == NUM_COL) begin
                        vec[num_vec] = fields;
                        num_vec++;
                    end else if (n_read != -1) begin
                        $display("vector line %0d is short or unreadable", num_vec + 1);
                        ok = 1'b0;
                    end
                end
                if (ok && !$feof(fd)) begin
                    $display("vector file holds more than %0d stimulus lines", MAX_VEC);
                    ok = 1'b0;
                end
                if (ok && num_vec == 0) begin
                    $display("vector file holds no stimulus lines after the maps");
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_vector(input int i);
        p1_valid_i    <= 1'(vec[i][0]);
        p1_dir_i      <= bomb_game_pkg::DIR_W'(vec[i][1]);
        p1_bomb_i     <= 1'(vec[i][2]);
        p1_bomb_num_i <= bomb_game_pkg::BOMB_CNT_W'(vec[i][3]);
        p1_bomb_max_i <= bomb_game_pkg::BOMB_CNT_W'(vec[i][4]);
        p2_valid_i    <= 1'(vec[i][5]);
        p2_dir_i      <= bomb_game_pkg::DIR_W'(vec[i][6]);
        p2_bomb_i     <= 1'(vec[i][7]);
        p2_bomb_num_i <= bomb_game_pkg::BOMB_CNT_W'(vec[i][8]);
        p2_bomb_max_i <= bomb_game_pkg::BOMB_CNT_W'(vec[i][9]);
    endtask

    task automatic verify_outputs(input int i);
        compare_field("p1_x_o", vec[i][10], int'(p1_x_o));
        compare_field("p1_y_o", vec[i][11], int'(p1_y_o));
        compare_field("p1_face_o", vec[i][12], int'(p1_face_o));
        compare_field("p1_set_bomb_o", vec[i][13], int'(p1_set_bomb_o));
        compare_field("p1_bomb_count_o", vec[i][14], int'(p1_bomb_count_o));
        // linear index is row-major, 16 cells per row
        compare_field("p1_cell_o", bomb_game_pkg::GRID_DIM * vec[i][11] + vec[i][10],
                      int'(p1_cell_o));
        compare_field("p2_x_o", vec[i][15], int'(p2_x_o));
        compare_field("p2_y_o", vec[i][16], int'(p2_y_o));
        compare_field("p2_face_o", vec[i][17], int'(p2_face_o));
        compare_field("p2_set_bomb_o", vec[i][18], int'(p2_set_bomb_o));
        compare_field("p2_bomb_count_o", vec[i][19], int'(p2_bomb_count_o));
        compare_field("p2_cell_o", bomb_game_pkg::GRID_DIM * vec[i][16] + vec[i][15],
                      int'(p2_cell_o));
    endtask

    initial begin
        bit load_ok;
        rst           = 1'b1;
        p1_valid_i    = 1'b0;
        p1_dir_i      = bomb_game_pkg::DIR_STOP;
        p1_bomb_i     = 1'b0;
        p1_bomb_num_i = '0;
        p1_bomb_max_i = '0;
        p2_valid_i    = 1'b0;
        p2_dir_i      = bomb_game_pkg::DIR_STOP;
        p2_bomb_i     = 1'b0;
        p2_bomb_num_i = '0;
        p2_bomb_max_i = '0;
        wall_map_i    = '0;
        bomb_map_i    = '0;
        load_vectors(load_ok);
        if (!load_ok) begin
            $display("Testbench failed");
            $finish;
        end else begin
            vectors_loaded = 1'b1;
            repeat (2) @(posedge clk);
            rst <= 1'b0;
            // outputs for row i settle one edge after it is driven
            for (int i = 0; i < num_vec; i++) begin
                @(posedge clk);
                drive_vector(i);
                @(negedge clk);
                if (i > 0) begin
                    verify_outputs(i - 1);
                end
            end
            @(posedge clk);
            @(negedge clk);
            verify_outputs(num_vec - 1);
            $display("%0d checks run, %0d errors", check_count, error_count);
            if (error_count == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

    // reset, one row per cycle, plus slack
    initial begin
        wait (vectors_loaded);
        #((num_vec + 10) * CLK_PERIOD);
        $display("watchdog expired, run did not finish within %0d cycles", num_vec + 10);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/game_controller.sv
`timescale 1ns/1ps
`default_nettype none

module game_controller (
    input  logic                                   clk,
    input  logic                                   rst,

    // player 1 commands
    input  logic                                   p1_valid_i,
    input  logic [bomb_game_pkg::DIR_W-1:0]        p1_dir_i,
    input  logic                                   p1_bomb_i,
    input  logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p1_bomb_num_i,
    input  logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p1_bomb_max_i,

    // player 2 commands
    input  logic                                   p2_valid_i,
    input  logic [bomb_game_pkg::DIR_W-1:0]        p2_dir_i,
    input  logic                                   p2_bomb_i,
    input  logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p2_bomb_num_i,
    input  logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p2_bomb_max_i,

    // board state, one bit per cell
    input  logic [bomb_game_pkg::CELL_COUNT-1:0]   wall_map_i,
    input  logic [bomb_game_pkg::CELL_COUNT-1:0]   bomb_map_i,

    // player 1 status
    output logic [bomb_game_pkg::COORD_W-1:0]      p1_x_o,
    output logic [bomb_game_pkg::COORD_W-1:0]      p1_y_o,
    output logic [bomb_game_pkg::CELL_W-1:0]       p1_cell_o,
    output logic [bomb_game_pkg::FACE_W-1:0]       p1_face_o,
    output logic                                   p1_set_bomb_o,
    output logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p1_bomb_count_o,

    // player 2 status
    output logic [bomb_game_pkg::COORD_W-1:0]      p2_x_o,
    output logic [bomb_game_pkg::COORD_W-1:0]      p2_y_o,
    output logic [bomb_game_pkg::CELL_W-1:0]       p2_cell_o,
    output logic [bomb_game_pkg::FACE_W-1:0]       p2_face_o,
    output logic                                   p2_set_bomb_o,
    output logic [bomb_game_pkg::BOMB_CNT_W-1:0]   p2_bomb_count_o
);

    bomb_game_pkg::cell_t p1_pos;
    bomb_game_pkg::cell_t p2_pos;

    player_cmd_if p1_cmd ();
    player_cmd_if p2_cmd ();

    // pins straight onto each player's command bundle
    assign p1_cmd.in_valid  = p1_valid_i;
    assign p1_cmd.direction = p1_dir_i;
    assign p1_cmd.bomb_req  = p1_bomb_i;
    assign p1_cmd.bomb_num  = p1_bomb_num_i;
    assign p1_cmd.bomb_max  = p1_bomb_max_i;

    assign p2_cmd.in_valid  = p2_valid_i;
    assign p2_cmd.direction = p2_dir_i;
    assign p2_cmd.bomb_req  = p2_bomb_i;
    assign p2_cmd.bomb_num  = p2_bomb_num_i;
    assign p2_cmd.bomb_max  = p2_bomb_max_i;

    move_unit #(
        .START_CELL (bomb_game_pkg::P1_START)
    ) u_p1_move (
        .clk        (clk),
        .rst        (rst),
        .cmd        (p1_cmd),
        .wall_map_i (wall_map_i),
        .bomb_map_i (bomb_map_i),
        .pos_o      (p1_pos),
        .face_o     (p1_face_o)
    );

    move_unit #(
        .START_CELL (bomb_game_pkg::P2_START)
    ) u_p2_move (
        .clk        (clk),
        .rst        (rst),
        .cmd        (p2_cmd),
        .wall_map_i (wall_map_i),
        .bomb_map_i (bomb_map_i),
        .pos_o      (p2_pos),
        .face_o     (p2_face_o)
    );

    bomb_unit u_p1_bomb (
        .clk          (clk),
        .rst          (rst),
        .cmd          (p1_cmd),
        .set_bomb_o   (p1_set_bomb_o),
        .bomb_count_o (p1_bomb_count_o)
    );

    bomb_unit u_p2_bomb (
        .clk          (clk),
        .rst          (rst),
        .cmd          (p2_cmd),
        .set_bomb_o   (p2_set_bomb_o),
        .bomb_count_o (p2_bomb_count_o)
    );

    // both views of the same position word
    assign p1_x_o    = p1_pos.xy.x;
    assign p1_y_o    = p1_pos.xy.y;
    assign p1_cell_o = p1_pos.idx;

    assign p2_x_o    = p2_pos.xy.x;
    assign p2_y_o    = p2_pos.xy.y;
    assign p2_cell_o = p2_pos.idx;

endmodule

`default_nettype wire

//--- source/bomb_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bomb_unit (
    input  logic                                   clk,
    input  logic                                   rst,
    player_cmd_if.sink                             cmd,
    output logic                                   set_bomb_o,
    output logic [bomb_game_pkg::BOMB_CNT_W-1:0]   bomb_count_o
);

    logic                                    bomb_rdy_q;
    logic [1:0]                              cool_q;
    logic                                    set_bomb_q;
    logic [bomb_game_pkg::BOMB_CNT_W-1:0]    count_q;
    logic                                    below_max;
    logic                                    place_acc;

    assign below_max = (cmd.bomb_num < cmd.bomb_max);
    assign place_acc = cmd.in_valid && cmd.bomb_req && bomb_rdy_q && below_max;

    // cooldown counter restarts on each placement
    // and saturates so it stays quiet while idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cool_q <= '0;
        end else if (place_acc) begin
            cool_q <= '0;
        end else if (cool_q != 2'd3) begin
            cool_q <= cool_q + 2'd1;
        end
    end

    // ready drops for two cycles after a placement
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bomb_rdy_q <= 1'b1;
        end else if (place_acc) begin
            bomb_rdy_q <= 1'b0;
        end else if (!bomb_rdy_q && cool_q != 2'd0) begin
            bomb_rdy_q <= 1'b1;
        end
    end

    // one-cycle pulse and wrapping placed count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            set_bomb_q <= 1'b0;
            count_q    <= '0;
        end else begin
            set_bomb_q <= place_acc;
            if (place_acc) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign set_bomb_o   = set_bomb_q;
    assign bomb_count_o = count_q;

    // cooldown keeps pulses apart even under a held request
    a_no_double_pulse: assert property (
        @(posedge clk) disable iff (rst)
        set_bomb_q |=> !set_bomb_q
    ) else $error("bomb_unit: set_bomb high on two consecutive cycles");

endmodule

`default_nettype wire

//--- source/move_unit.sv
`timescale 1ns/1ps
`default_nettype none

module move_unit #(
    parameter bomb_game_pkg::cell_t START_CELL = bomb_game_pkg::P1_START
) (
    input  logic                                   clk,
    input  logic                                   rst,
    player_cmd_if.sink                             cmd,
    input  logic [bomb_game_pkg::CELL_COUNT-1:0]   wall_map_i,
    input  logic [bomb_game_pkg::CELL_COUNT-1:0]   bomb_map_i,
    output bomb_game_pkg::cell_t                   pos_o,
    output logic [bomb_game_pkg::FACE_W-1:0]       face_o
);

    bomb_game_pkg::cell_t                 pos_q;
    bomb_game_pkg::cell_t                 target;
    logic [bomb_game_pkg::FACE_W-1:0]     face_q;
    logic                                 move_rdy_q;
    logic                                 moving_dir;
    logic                                 step_acc;
    logic                                 off_board;
    logic                                 blocked;

    assign moving_dir = (cmd.direction != bomb_game_pkg::DIR_STOP);
    assign step_acc   = cmd.in_valid && moving_dir && move_rdy_q;

    // neighbour cell and edge check for the requested direction
    always_comb begin
        target    = pos_q;
        off_board = 1'b0;
        case (cmd.direction)
            bomb_game_pkg::DIR_UP: begin
                off_board     = (pos_q.xy.y == '0);
                target.xy.y   = pos_q.xy.y - 1'b1;
            end
            bomb_game_pkg::DIR_DOWN: begin
                off_board     = (pos_q.xy.y == bomb_game_pkg::COORD_W'(bomb_game_pkg::GRID_DIM - 1));
                target.xy.y   = pos_q.xy.y + 1'b1;
            end
            bomb_game_pkg::DIR_LEFT: begin
                off_board     = (pos_q.xy.x == '0);
                target.xy.x   = pos_q.xy.x - 1'b1;
            end
            bomb_game_pkg::DIR_RIGHT: begin
                off_board     = (pos_q.xy.x == bomb_game_pkg::COORD_W'(bomb_game_pkg::GRID_DIM - 1));
                target.xy.x   = pos_q.xy.x + 1'b1;
            end
            default: begin
                // stop and unused codes never move
                off_board = 1'b1;
            end
        endcase
    end

    // walls and placed bombs both block
    assign blocked = off_board || wall_map_i[target.idx] || bomb_map_i[target.idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos_q      <= START_CELL;
            face_q     <= '0;
            move_rdy_q <= 1'b1;
        end else begin
            // a blocked step still costs the cooldown
            move_rdy_q <= ~step_acc;
            if (step_acc && !blocked) begin
                pos_q <= target;
            end
            // facing follows the code even without in_valid
            if (moving_dir) begin
                face_q <= cmd.direction[bomb_game_pkg::FACE_W-1:0];
            end
        end
    end

    assign pos_o  = pos_q;
    assign face_o = face_q;

    // single orthogonal step per clock, never a wrap across the board
    a_single_step: assert property (
        @(posedge clk) disable iff (rst)
        ((pos_q.xy.x == $past(pos_q.xy.x)) &&
         ((pos_q.xy.y == $past(pos_q.xy.y)) ||
          (pos_q.xy.y == $past(pos_q.xy.y) + 1) ||
          (pos_q.xy.y == $past(pos_q.xy.y) - 1))) ||
        ((pos_q.xy.y == $past(pos_q.xy.y)) &&
         ((pos_q.xy.x == $past(pos_q.xy.x) + 1) ||
          (pos_q.xy.x == $past(pos_q.xy.x) - 1)))
    ) else $error("move_unit: position jumped by more than one cell");

endmodule

`default_nettype wire

//--- source/player_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// one player's command port, fanned out to the move and bomb units
interface player_cmd_if;

    logic                                in_valid;
    logic [bomb_game_pkg::DIR_W-1:0]      direction;
    logic                                bomb_req;
    logic [bomb_game_pkg::BOMB_CNT_W-1:0] bomb_num;
    logic [bomb_game_pkg::BOMB_CNT_W-1:0] bomb_max;

    // driver side, fed from the top-level pins
    modport src (
        output in_valid,
        output direction,
        output bomb_req,
        output bomb_num,
        output bomb_max
    );

    // receiving units
    modport sink (
        input in_valid,
        input direction,
        input bomb_req,
        input bomb_num,
        input bomb_max
    );

endinterface

`default_nettype wire

//--- source/bomb_game_pkg.sv
`default_nettype none

package bomb_game_pkg;

    // board geometry
    localparam int GRID_DIM   = 16;
    localparam int COORD_W    = 4;
    localparam int CELL_W     = 8;
    localparam int CELL_COUNT = 256;

    // direction codes on the command port
    localparam int DIR_W = 3;
    localparam logic [DIR_W-1:0] DIR_UP    = 3'd0;
    localparam logic [DIR_W-1:0] DIR_DOWN  = 3'd1;
    localparam logic [DIR_W-1:0] DIR_LEFT  = 3'd2;
    localparam logic [DIR_W-1:0] DIR_RIGHT = 3'd3;
    localparam logic [DIR_W-1:0] DIR_STOP  = 3'd4;

    // facing keeps only the low bits of the last moving code
    localparam int FACE_W = 2;

    localparam int BOMB_CNT_W = 3;

    // y in the upper nibble, x in the lower nibble
    typedef struct packed {
        logic [COORD_W-1:0] y;
        logic [COORD_W-1:0] x;
    } cell_xy_t;

    // one board cell, read as linear index for map lookup
    // or as a coordinate pair for step arithmetic
    typedef union packed {
        logic [CELL_W-1:0] idx;
        cell_xy_t          xy;
    } cell_t;

    // start cells (0,0) and (15,15)
    localparam cell_t P1_START = cell_t'(CELL_W'(0));
    localparam cell_t P2_START = cell_t'(CELL_W'(CELL_COUNT - 1));

endpackage

`default_nettype wire
